/* core_isa_pkg.sv */
package core_isa_pkg;

    // ----------------------------------------
    // machine sizes
    // ----------------------------------------
    localparam int unsigned xlen      = 32;
    localparam int unsigned reg_count = 32;
    localparam logic [xlen-1:0] reset_pc = '0;

    // major opcodes of the supported subset
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_jal    = 7'b1101111;

    // funct3 for alu operations
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl     = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    // funct3 for branches
    localparam logic [2:0] f3_beq = 3'b000;
    localparam logic [2:0] f3_bne = 3'b001;
    localparam logic [2:0] f3_blt = 3'b100;

    // only SUB needs the upper funct7 bit
    localparam logic [6:0] f7_sub = 7'b0100000;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sll,
        alu_srl,
        alu_pass_b
    } alu_op_e;

    typedef enum logic [1:0] {
        br_none,
        br_beq,
        br_bne,
        br_blt
    } br_op_e;

    // ----------------------------------------
    // instruction formats
    // ----------------------------------------
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one fetched word, viewed through whichever format decode needs
    typedef union packed {
        logic [31:0] raw;
        r_fmt_t      r;
        i_fmt_t      i;
        s_fmt_t      s;
        b_fmt_t      b;
        u_fmt_t      u;
        j_fmt_t      j;
    } instr_u;

endpackage

/* core_pipe_pkg.sv */
package core_pipe_pkg;

    import core_isa_pkg::*;

    // ----------------------------------------
    // pipeline registers
    // ----------------------------------------
    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [31:0]     instr;
        logic            valid;
    } if_id_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [xlen-1:0] rs1_val;
        logic [xlen-1:0] rs2_val;
        logic [xlen-1:0] imm;
        alu_op_e         alu_op;
        br_op_e          br_op;
        logic            use_imm;
        logic            is_jal;
        logic            mem_read;
        logic            mem_write;
        logic            reg_write;
        logic [4:0]      rd;
        logic            valid;
    } id_ex_t;

    typedef struct packed {
        logic [xlen-1:0] result;
        logic [xlen-1:0] store_data;
        logic            mem_read;
        logic            mem_write;
        logic            reg_write;
        logic [4:0]      rd;
        logic            valid;
    } ex_mem_t;

    // register file write, also the oldest forwarding source
    typedef struct packed {
        logic            we;
        logic [4:0]      rd;
        logic [xlen-1:0] data;
    } wb_t;

    // ----------------------------------------
    // ports and control
    // ----------------------------------------
    typedef struct packed {
        logic            read;
        logic            write;
        logic [xlen-1:0] addr;
        logic [xlen-1:0] wdata;
    } dmem_req_t;

    typedef struct packed {
        logic            taken;
        logic [xlen-1:0] target;
    } redirect_t;

    // stall_x holds the input register of stage x, flush_x empties it
    typedef struct packed {
        logic stall_fetch;
        logic stall_decode;
        logic stall_execute;
        logic flush_decode;
        logic flush_execute;
        logic stall_memory;
    } stage_ctrl_t;

endpackage

/* fetch_stage.sv */
module fetch_stage
    import core_isa_pkg::*;
    import core_pipe_pkg::*;
(
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  stage_ctrl_t     ctrl_i,
    input  redirect_t       redirect_i,
    input  logic            imem_ready_i,
    input  logic [xlen-1:0] imem_data_i,
    output logic [xlen-1:0] imem_addr_o,
    output logic            imem_req_o,
    output if_id_t          if_id_o
);

    logic [xlen-1:0] pc_q;
    logic            run_q;
    logic            accept;

    // request drops while stalled, and for the one cycle the pc is replaced
    assign imem_req_o  = run_q & ~ctrl_i.stall_fetch & ~redirect_i.taken;
    assign imem_addr_o = pc_q;
    assign accept      = imem_req_o & imem_ready_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            run_q <= 1'b0;
            pc_q  <= reset_pc;
        end else begin
            run_q <= 1'b1;
            if (redirect_i.taken) begin
                pc_q <= redirect_i.target;
            end else if (accept) begin
                pc_q <= pc_q + xlen'(4);
            end
        end
    end

    // fetch/decode register
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            if_id_o <= '0;
        end else if (ctrl_i.flush_decode) begin
            if_id_o.valid <= 1'b0;
        end else if (!ctrl_i.stall_decode) begin
            if_id_o.pc    <= pc_q;
            if_id_o.instr <= imem_data_i;
            if_id_o.valid <= accept;
        end
    end

endmodule

/* decode_stage.sv */
module decode_stage
    import core_isa_pkg::*;
    import core_pipe_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  stage_ctrl_t ctrl_i,
    input  if_id_t      if_id_i,
    input  wb_t         wb_i,
    output id_ex_t      id_ex_o,
    output logic        load_use_o
);

    instr_u          instr;
    logic [xlen-1:0] regs [reg_count];
    logic            uses_rs1;
    logic            uses_rs2;
    logic [4:0]      rs1_idx;
    logic [4:0]      rs2_idx;
    id_ex_t          id_ex_d;

    assign instr = if_id_i.instr;

    function automatic alu_op_e alu_of(input logic [2:0] funct3, input logic sub);
        alu_op_e op;
        case (funct3)
            f3_add_sub: op = sub ? alu_sub : alu_add;
            f3_sll:     op = alu_sll;
            f3_slt:     op = alu_slt;
            f3_xor:     op = alu_xor;
            f3_srl:     op = alu_srl;
            f3_or:      op = alu_or;
            f3_and:     op = alu_and;
            default:    op = alu_add;
        endcase
        return op;
    endfunction

    // x0 reads as zero, a write in progress is seen in the same cycle
    function automatic logic [xlen-1:0] reg_read(input logic [4:0] idx);
        logic [xlen-1:0] val;
        if (idx == '0) begin
            val = '0;
        end else if (wb_i.we && wb_i.rd == idx) begin
            val = wb_i.data;
        end else begin
            val = regs[idx];
        end
        return val;
    endfunction

    // ----------------------------------------
    // instruction decode
    // ----------------------------------------
    always_comb begin
        id_ex_d       = '0;
        uses_rs1      = 1'b0;
        uses_rs2      = 1'b0;
        id_ex_d.pc    = if_id_i.pc;
        id_ex_d.rd    = instr.r.rd;
        id_ex_d.valid = if_id_i.valid;
        case (instr.r.opcode)
            opc_op: begin
                uses_rs1          = 1'b1;
                uses_rs2          = 1'b1;
                id_ex_d.reg_write = 1'b1;
                id_ex_d.alu_op    = alu_of(instr.r.funct3, instr.r.funct7 == f7_sub);
            end
            opc_op_imm: begin
                uses_rs1          = 1'b1;
                id_ex_d.use_imm   = 1'b1;
                id_ex_d.reg_write = 1'b1;
                id_ex_d.imm       = {{20{instr.i.imm[11]}}, instr.i.imm};
                id_ex_d.alu_op    = alu_of(instr.i.funct3, 1'b0);
            end
            opc_lui: begin
                id_ex_d.use_imm   = 1'b1;
                id_ex_d.reg_write = 1'b1;
                id_ex_d.imm       = {instr.u.imm, 12'b0};
                id_ex_d.alu_op    = alu_pass_b;
            end
            opc_load: begin
                uses_rs1          = 1'b1;
                id_ex_d.use_imm   = 1'b1;
                id_ex_d.mem_read  = 1'b1;
                id_ex_d.reg_write = 1'b1;
                id_ex_d.imm       = {{20{instr.i.imm[11]}}, instr.i.imm};
            end
            opc_store: begin
                uses_rs1          = 1'b1;
                uses_rs2          = 1'b1;
                id_ex_d.use_imm   = 1'b1;
                id_ex_d.mem_write = 1'b1;
                id_ex_d.imm       = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
            end
            opc_branch: begin
                uses_rs1    = 1'b1;
                uses_rs2    = 1'b1;
                id_ex_d.imm = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                               instr.b.imm10_5, instr.b.imm4_1, 1'b0};
                case (instr.b.funct3)
                    f3_beq:  id_ex_d.br_op = br_beq;
                    f3_bne:  id_ex_d.br_op = br_bne;
                    f3_blt:  id_ex_d.br_op = br_blt;
                    default: id_ex_d.br_op = br_none;
                endcase
            end
            opc_jal: begin
                id_ex_d.is_jal    = 1'b1;
                id_ex_d.reg_write = 1'b1;
                id_ex_d.imm       = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.imm19_12,
                                     instr.j.imm11, instr.j.imm10_1, 1'b0};
            end
            default: ;
        endcase

        // unused source fields read as x0 so they never match a hazard
        rs1_idx           = uses_rs1 ? instr.r.rs1 : '0;
        rs2_idx           = uses_rs2 ? instr.r.rs2 : '0;
        id_ex_d.rs1       = rs1_idx;
        id_ex_d.rs2       = rs2_idx;
        id_ex_d.rs1_val   = reg_read(rs1_idx);
        id_ex_d.rs2_val   = reg_read(rs2_idx);
        id_ex_d.reg_write = id_ex_d.reg_write & (instr.r.rd != '0);
    end

    // register file
    always_ff @(posedge clk_i) begin
        if (wb_i.we) begin
            regs[wb_i.rd] <= wb_i.data;
        end
    end

    // load in execute feeding the instruction in decode
    assign load_use_o = if_id_i.valid & id_ex_o.valid & id_ex_o.mem_read
                      & (id_ex_o.rd != '0)
                      & ((id_ex_o.rd == rs1_idx) | (id_ex_o.rd == rs2_idx));

    // decode/execute register
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || ctrl_i.flush_execute) begin
            id_ex_o <= '0;
        end else if (!ctrl_i.stall_execute) begin
            id_ex_o <= id_ex_d;
        end
    end

endmodule

/* execute_stage.sv */
module execute_stage
    import core_isa_pkg::*;
    import core_pipe_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  stage_ctrl_t ctrl_i,
    input  id_ex_t      id_ex_i,
    input  wb_t         wb_i,
    output ex_mem_t     ex_mem_o,
    output redirect_t   redirect_o
);

    logic [xlen-1:0] op_a;
    logic [xlen-1:0] rs2_fwd;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] alu_res;
    logic [xlen-1:0] target;
    logic            ex_valid;
    logic            cond;
    logic            taken;
    ex_mem_t         ex_mem_d;

    // youngest producer wins; a load in memory has no data yet
    function automatic logic [xlen-1:0] forward(input logic [4:0] idx,
                                                input logic [xlen-1:0] val);
        logic [xlen-1:0] res;
        res = val;
        if (wb_i.we && wb_i.rd == idx) begin
            res = wb_i.data;
        end
        if (ex_mem_o.reg_write && !ex_mem_o.mem_read && ex_mem_o.rd == idx) begin
            res = ex_mem_o.result;
        end
        return res;
    endfunction

    assign op_a    = forward(id_ex_i.rs1, id_ex_i.rs1_val);
    assign rs2_fwd = forward(id_ex_i.rs2, id_ex_i.rs2_val);
    assign op_b    = id_ex_i.use_imm ? id_ex_i.imm : rs2_fwd;

    // ----------------------------------------
    // alu and branch compare
    // ----------------------------------------
    always_comb begin
        case (id_ex_i.alu_op)
            alu_add:    alu_res = op_a + op_b;
            alu_sub:    alu_res = op_a - op_b;
            alu_and:    alu_res = op_a & op_b;
            alu_or:     alu_res = op_a | op_b;
            alu_xor:    alu_res = op_a ^ op_b;
            alu_slt:    alu_res = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            alu_sll:    alu_res = op_a << op_b[4:0];
            alu_srl:    alu_res = op_a >> op_b[4:0];
            alu_pass_b: alu_res = op_b;
            default:    alu_res = op_a + op_b;
        endcase
    end

    always_comb begin
        case (id_ex_i.br_op)
            br_beq:  cond = (op_a == rs2_fwd);
            br_bne:  cond = (op_a != rs2_fwd);
            br_blt:  cond = ($signed(op_a) < $signed(rs2_fwd));
            default: cond = 1'b0;
        endcase
    end

    // the instruction behind a taken branch is squashed here
    assign ex_valid = id_ex_i.valid & ~redirect_o.taken;
    assign taken    = ex_valid & (id_ex_i.is_jal | cond);
    assign target   = id_ex_i.pc + id_ex_i.imm;

    always_comb begin
        ex_mem_d.result     = id_ex_i.is_jal ? id_ex_i.pc + xlen'(4) : alu_res;
        ex_mem_d.store_data = rs2_fwd;
        ex_mem_d.mem_read   = ex_valid & id_ex_i.mem_read;
        ex_mem_d.mem_write  = ex_valid & id_ex_i.mem_write;
        ex_mem_d.reg_write  = ex_valid & id_ex_i.reg_write;
        ex_mem_d.rd         = id_ex_i.rd;
        ex_mem_d.valid      = ex_valid;
    end

    // execute/memory register, redirect leaves one cycle behind the branch
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ex_mem_o   <= '0;
            redirect_o <= '0;
        end else if (ctrl_i.stall_memory) begin
            redirect_o.taken <= 1'b0;
        end else begin
            ex_mem_o          <= ex_mem_d;
            redirect_o.taken  <= taken;
            redirect_o.target <= target;
        end
    end

endmodule

/* memory_stage.sv */
module memory_stage
    import core_isa_pkg::*;
    import core_pipe_pkg::*;
(
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  stage_ctrl_t     ctrl_i,
    input  ex_mem_t         ex_mem_i,
    input  logic [xlen-1:0] dmem_rdata_i,
    input  logic            dmem_ready_i,
    output dmem_req_t       dmem_req_o,
    output logic            mem_wait_o,
    output wb_t             wb_o
);

    logic access;

    // data port follows the held execute/memory register
    assign dmem_req_o.read  = ex_mem_i.mem_read;
    assign dmem_req_o.write = ex_mem_i.mem_write;
    assign dmem_req_o.addr  = ex_mem_i.result;
    assign dmem_req_o.wdata = ex_mem_i.store_data;

    assign access     = ex_mem_i.mem_read | ex_mem_i.mem_write;
    assign mem_wait_o = access & ~dmem_ready_i;

    // ----------------------------------------
    // write-back register
    // ----------------------------------------
    // held during a wait so execute keeps its forwarding source
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wb_o <= '0;
        end else if (!ctrl_i.stall_memory) begin
            wb_o.we   <= ex_mem_i.reg_write;
            wb_o.rd   <= ex_mem_i.rd;
            wb_o.data <= ex_mem_i.mem_read ? dmem_rdata_i : ex_mem_i.result;
        end
    end

endmodule

/* pipeline_controller.sv */
module pipeline_controller
    import core_pipe_pkg::*;
(
    input  logic        load_use_i,
    input  logic        mem_wait_i,
    input  redirect_t   redirect_i,
    output stage_ctrl_t ctrl_o
);

    logic hazard_stall;
    logic squash;

    // the load-use pair is dead anyway once a redirect is out
    assign hazard_stall = load_use_i & ~redirect_i.taken;
    assign squash       = redirect_i.taken;

    // memory wait freezes everything and masks the rest
    always_comb begin
        ctrl_o.stall_fetch   = mem_wait_i | hazard_stall;
        ctrl_o.stall_decode  = mem_wait_i | hazard_stall;
        ctrl_o.stall_execute = mem_wait_i;
        ctrl_o.stall_memory  = mem_wait_i;
        ctrl_o.flush_decode  = ~mem_wait_i & squash;
        ctrl_o.flush_execute = ~mem_wait_i & (squash | hazard_stall);
    end

endmodule

/* core_top.sv */
module core_top
    import core_isa_pkg::*;
    import core_pipe_pkg::*;
(
    input  logic            clk_i,
    input  logic            rst_n_i,

    // instruction port
    output logic [xlen-1:0] imem_addr_o,
    output logic            imem_req_o,
    input  logic [xlen-1:0] imem_data_i,
    input  logic            imem_ready_i,

    // data port
    output dmem_req_t       dmem_req_o,
    input  logic [xlen-1:0] dmem_rdata_i,
    input  logic            dmem_ready_i
);

    if_id_t      if_id;
    id_ex_t      id_ex;
    ex_mem_t     ex_mem;
    wb_t         wb;
    redirect_t   redirect;
    stage_ctrl_t ctrl;
    logic        load_use;
    logic        mem_wait;

    // ----------------------------------------
    // stages
    // ----------------------------------------
    fetch_stage i_fetch (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .ctrl_i       (ctrl),
        .redirect_i   (redirect),
        .imem_ready_i (imem_ready_i),
        .imem_data_i  (imem_data_i),
        .imem_addr_o  (imem_addr_o),
        .imem_req_o   (imem_req_o),
        .if_id_o      (if_id)
    );

    decode_stage i_decode (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .ctrl_i     (ctrl),
        .if_id_i    (if_id),
        .wb_i       (wb),
        .id_ex_o    (id_ex),
        .load_use_o (load_use)
    );

    execute_stage i_execute (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .ctrl_i     (ctrl),
        .id_ex_i    (id_ex),
        .wb_i       (wb),
        .ex_mem_o   (ex_mem),
        .redirect_o (redirect)
    );

    memory_stage i_memory (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .ctrl_i       (ctrl),
        .ex_mem_i     (ex_mem),
        .dmem_rdata_i (dmem_rdata_i),
        .dmem_ready_i (dmem_ready_i),
        .dmem_req_o   (dmem_req_o),
        .mem_wait_o   (mem_wait),
        .wb_o         (wb)
    );

    // stall and flush for every stage
    pipeline_controller i_ctrl (
        .load_use_i (load_use),
        .mem_wait_i (mem_wait),
        .redirect_i (redirect),
        .ctrl_o     (ctrl)
    );

endmodule

/* tb_core_model.svh */
`ifndef TB_CORE_MODEL_SVH
`define TB_CORE_MODEL_SVH

// ----------------------------------------
// instruction encoders
// ----------------------------------------
function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                      input int rd, input int rs1, input int rs2);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], opc_op};
endfunction

function automatic logic [31:0] enc_i(input logic [6:0] opc, input logic [2:0] f3,
                                      input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
endfunction

// word store, rs2 to imm(rs1)
function automatic logic [31:0] enc_s(input int rs2, input int rs1, input int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], opc_store};
endfunction

function automatic logic [31:0] enc_b(input logic [2:0] f3, input int rs1, input int rs2,
                                      input int imm);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], opc_branch};
endfunction

function automatic logic [31:0] enc_u(input int rd, input int imm);
    return {imm[19:0], rd[4:0], opc_lui};
endfunction

function automatic logic [31:0] enc_j(input int rd, input int imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], opc_jal};
endfunction

// ----------------------------------------
// program image
// ----------------------------------------
task automatic load_program();
    // unused words hold the halt loop
    for (int i = 0; i < mem_words; i++) begin
        prog[i] = enc_j(0, 0);
    end
    prog[0]  = enc_i(opc_op_imm, f3_add_sub, 1, 0, -5);
    prog[1]  = enc_i(opc_op_imm, f3_add_sub, 2, 0, 3);
    // back to back dependencies
    prog[2]  = enc_r(7'b0, f3_add_sub, 3, 1, 2);
    prog[3]  = enc_r(f7_sub, f3_add_sub, 4, 3, 1);
    prog[4]  = enc_s(3, 0, 0);
    prog[5]  = enc_s(4, 0, 4);
    prog[6]  = enc_r(7'b0, f3_slt, 5, 1, 2);
    prog[7]  = enc_r(7'b0, f3_slt, 6, 2, 1);
    prog[8]  = enc_s(5, 0, 8);
    prog[9]  = enc_s(6, 0, 12);
    // shifts by 31 and by 0
    prog[10] = enc_u(7, 32'h80000);
    prog[11] = enc_i(opc_op_imm, f3_add_sub, 9, 0, 31);
    prog[12] = enc_r(7'b0, f3_srl, 8, 7, 9);
    prog[13] = enc_r(7'b0, f3_sll, 10, 2, 9);
    prog[14] = enc_r(7'b0, f3_sll, 11, 2, 0);
    prog[15] = enc_s(8, 0, 16);
    prog[16] = enc_s(10, 0, 20);
    prog[17] = enc_s(11, 0, 24);
    prog[18] = enc_r(7'b0, f3_and, 12, 1, 2);
    prog[19] = enc_r(7'b0, f3_or, 13, 1, 2);
    prog[20] = enc_r(7'b0, f3_xor, 14, 12, 13);
    prog[21] = enc_s(14, 0, 28);
    // load used by the very next instruction
    prog[22] = enc_i(opc_load, 3'b010, 15, 0, 28);
    prog[23] = enc_i(opc_op_imm, f3_add_sub, 16, 15, 1);
    prog[24] = enc_s(16, 0, 32);
    // x0 stays zero
    prog[25] = enc_r(7'b0, f3_add_sub, 0, 1, 2);
    prog[26] = enc_s(0, 0, 36);
    prog[27] = enc_b(f3_beq, 1, 2, 8);
    prog[28] = enc_s(1, 0, 40);
    prog[29] = enc_b(f3_bne, 1, 2, 8);
    prog[30] = enc_s(2, 0, 44);
    prog[31] = enc_b(f3_blt, 1, 2, 8);
    prog[32] = enc_s(2, 0, 48);
    prog[33] = enc_b(f3_blt, 2, 1, 8);
    prog[34] = enc_j(17, 8);
    prog[35] = enc_s(2, 0, 52);
    prog[36] = enc_s(17, 0, 56);
    prog[37] = enc_j(0, 0);
endtask

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

// initial data memory contents
function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return (addr * 32'h0101_0101) ^ 32'h5a5a_3c3c;
endfunction

// ----------------------------------------
// reference ISA model
// ----------------------------------------
function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic sub,
                                        input logic [31:0] a, input logic [31:0] b);
    logic [31:0] r;
    case (f3)
        3'b000:  r = sub ? a - b : a + b;
        3'b001:  r = a << b[4:0];
        3'b010:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'b100:  r = a ^ b;
        3'b101:  r = a >> b[4:0];
        3'b110:  r = a | b;
        default: r = a & b;
    endcase
    return r;
endfunction

// runs the image until the jump to itself, collecting every store
function automatic void run_model();
    logic [31:0] xr [32];
    logic [31:0] pc;
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic [31:0] addr;
    logic [31:0] next_pc;
    logic        done;
    int          steps;
    dmem_req_t   rec;
    for (int i = 0; i < 32; i++) begin
        xr[i] = '0;
    end
    for (int i = 0; i < mem_words; i++) begin
        model_mem[i] = fill_word(32'(i * 4));
    end
    exp_q.delete();
    pc    = reset_pc;
    done  = 1'b0;
    steps = 0;
    while (!done && steps < 500) begin
        ins     = prog[pc[7:2]];
        a       = xr[ins[19:15]];
        b       = xr[ins[24:20]];
        imm_i   = {{20{ins[31]}}, ins[31:20]};
        imm_s   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b   = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j   = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        next_pc = pc + 32'd4;
        case (ins[6:0])
            opc_op:     xr[ins[11:7]] = alu_ref(ins[14:12], ins[30], a, b);
            opc_op_imm: xr[ins[11:7]] = alu_ref(ins[14:12], 1'b0, a, imm_i);
            opc_lui:    xr[ins[11:7]] = {ins[31:12], 12'b0};
            opc_load: begin
                addr          = a + imm_i;
                xr[ins[11:7]] = model_mem[addr[7:2]];
            end
            opc_store: begin
                addr                 = a + imm_s;
                model_mem[addr[7:2]] = b;
                rec                  = '0;
                rec.write            = 1'b1;
                rec.addr             = addr;
                rec.wdata            = b;
                exp_q.push_back(rec);
            end
            opc_branch: begin
                if ((ins[14:12] == 3'b000 && a == b) ||
                    (ins[14:12] == 3'b001 && a != b) ||
                    (ins[14:12] == 3'b100 && $signed(a) < $signed(b))) begin
                    next_pc = pc + imm_b;
                end
            end
            opc_jal: begin
                done          = (imm_j == '0);
                xr[ins[11:7]] = pc + 32'd4;
                next_pc       = pc + imm_j;
            end
            default: ;
        endcase
        xr[0] = '0;
        pc    = next_pc;
        steps++;
    end
endfunction

// ----------------------------------------
// compare tasks
// ----------------------------------------
task automatic check_store(input string name, input dmem_req_t exp, input dmem_req_t act);
    if (exp !== act) begin
        $display("FAIL %s expected %h actual %h", name, exp, act);
        stop_with_failure();
    end
endtask

task automatic check_word(input string name, input logic [xlen-1:0] exp,
                          input logic [xlen-1:0] act);
    if (exp !== act) begin
        $display("FAIL %s expected %h actual %h", name, exp, act);
        stop_with_failure();
    end
endtask

`endif

/* tb_core_top.sv */
module tb_core_top
    import core_isa_pkg::*;
    import core_pipe_pkg::*;
();

    localparam int          wait_limit = 3000;
    localparam int          mem_words  = 64;
    localparam logic [31:0] halt_pc    = 32'd148;

    logic            clk        = 1'b0;
    logic            rst_n      = 1'b0;
    logic [xlen-1:0] imem_addr;
    logic            imem_req;
    logic [xlen-1:0] imem_data  = '0;
    logic            imem_ready = 1'b0;
    dmem_req_t       dmem_req;
    logic [xlen-1:0] dmem_rdata = '0;
    logic            dmem_ready = 1'b0;

    logic [31:0] prog [mem_words];
    logic [31:0] dmem [mem_words];
    logic [31:0] model_mem [mem_words];
    dmem_req_t   exp_q [$];
    int          store_count = 0;

    logic [31:0] rng   = 32'd29;
    logic [1:0]  iwait = '0;
    logic [1:0]  dwait = '0;
    logic [31:0] fetch_addr;

    always #5 clk = ~clk;

    core_top i_dut (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .imem_addr_o  (imem_addr),
        .imem_req_o   (imem_req),
        .imem_data_i  (imem_data),
        .imem_ready_i (imem_ready),
        .dmem_req_o   (dmem_req),
        .dmem_rdata_i (dmem_rdata),
        .dmem_ready_i (dmem_ready)
    );

    task automatic stop_with_failure();
        $display("TB FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    `include "tb_core_model.svh"

    // a ready pulse that met the request moved the pc on by one word
    assign fetch_addr = (imem_ready && imem_req) ? imem_addr + 32'd4 : imem_addr;

    // ----------------------------------------
    // memory models
    // ----------------------------------------
    always @(posedge clk) begin
        if (!rst_n) begin
            imem_ready <= 1'b0;
            dmem_ready <= 1'b0;
            iwait      <= 2'd0;
            dwait      <= 2'd0;
            rng        <= 32'd29;
            for (int i = 0; i < mem_words; i++) begin
                dmem[i] <= fill_word(32'(i * 4));
            end
        end else begin
            rng        <= xorshift32(rng);
            imem_ready <= 1'b0;
            dmem_ready <= 1'b0;
            if (imem_req) begin
                if (iwait == 2'd0) begin
                    imem_ready <= 1'b1;
                    imem_data  <= prog[fetch_addr[7:2]];
                    iwait      <= rng[1:0];
                end else begin
                    iwait <= iwait - 2'd1;
                end
            end
            // request is held until the cycle after ready
            if (dmem_ready) begin
                if (dmem_req.write) begin
                    dmem[dmem_req.addr[7:2]] <= dmem_req.wdata;
                end
            end else if (dmem_req.read || dmem_req.write) begin
                if (dwait == 2'd0) begin
                    dmem_ready <= 1'b1;
                    dmem_rdata <= dmem[dmem_req.addr[7:2]];
                    dwait      <= rng[9:8];
                end else begin
                    dwait <= dwait - 2'd1;
                end
            end
        end
    end

    // accepted stores against the model's ordered list
    always @(posedge clk) begin
        if (rst_n && dmem_ready && dmem_req.write) begin
            if (exp_q.size() == 0) begin
                $display("store to address %h came after the last expected store",
                         dmem_req.addr);
                stop_with_failure();
            end else begin
                check_store($sformatf("store %0d", store_count), exp_q.pop_front(), dmem_req);
                store_count++;
            end
        end
    end

    // ----------------------------------------
    // run control
    // ----------------------------------------
    initial begin
        int cycles;
        load_program();
        run_model();
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        cycles = 0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
            cycles++;
            if (cycles > wait_limit) begin
                $display("timeout with %0d stores still missing", exp_q.size());
                stop_with_failure();
            end
        end

        cycles = 0;
        while (!(imem_req && imem_addr == halt_pc)) begin
            @(negedge clk);
            cycles++;
            if (cycles > wait_limit) begin
                $display("timeout, the core never fetched the halt loop");
                stop_with_failure();
            end
        end

        for (int i = 0; i < mem_words; i++) begin
            check_word($sformatf("memory word %0d", i), model_mem[i], dmem[i]);
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

/* core_top.f */
+incdir+.
core_isa_pkg.sv
core_pipe_pkg.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
pipeline_controller.sv
core_top.sv
tb_core_top.sv

/* Makefile */
SIM      ?= verilator
FLAGS    ?= --binary
TOP      ?= tb_core_top
FILELIST ?= core_top.f

BUILD := obj_dir
BIN   := $(BUILD)/V$(TOP)
SRCS  := $(shell grep -v '^+' $(FILELIST)) tb_core_model.svh

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > sim.log 2>&1 || true
	@cat sim.log
	@grep -q "TB PASSED" sim.log || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf $(BUILD) sim.log
